// File: bench/ccu_wr_model.svh
`ifndef CCU_WR_MODEL_SVH
`define CCU_WR_MODEL_SVH

localparam int NUM_WRITES = 40;
localparam int MAX_BEATS  = 4;

// Expected memory write address and beat
typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              wrap;
} mem_aw_t;

typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
} beat_t;

// Writes issued by the master and generated before the run
logic [ADDR_W-1:0]      wr_addr [NUM_WRITES];
wr_op_e                 wr_op [NUM_WRITES];
domain_e                wr_dom [NUM_WRITES];
logic [NUM_MASTERS-1:0] wr_inner [NUM_WRITES];
logic [NUM_MASTERS-1:0] wr_outer [NUM_WRITES];
logic [NUM_MASTERS-1:0] wr_init [NUM_WRITES];
int                     wr_len [NUM_WRITES];
logic [DATA_W-1:0]      wr_data [NUM_WRITES][MAX_BEATS];

// Scoreboard queues in memory order
mem_aw_t           exp_aw_q[$];
beat_t             exp_w_q[$];
bit                b_kind_q[$];
logic [RESP_W-1:0] exp_b_q[$];

// A full-line write needs no data back from the snooped cache
function automatic snoop_op_e expected_snoop_op(input wr_op_e op);
    return (op == WRITE_LINE_UNIQUE) ? MAKE_INVALID : CLEAN_INVALID;
endfunction

function automatic logic [NUM_MASTERS-1:0] domain_targets(
    input domain_e                dom,
    input logic [NUM_MASTERS-1:0] inner,
    input logic [NUM_MASTERS-1:0] outer,
    input logic [NUM_MASTERS-1:0] initiator
);
    if (dom == INNER_SHAREABLE) return inner;
    if (dom == OUTER_SHAREABLE) return outer;
    if (dom == SYSTEM) return ~initiator;
    return '0;
endfunction

// Only dirty data without error goes back to memory
function automatic bit needs_writeback(input logic [CR_RESP_W-1:0] resp);
    return resp[CR_DATA_XFER] && resp[CR_PASS_DIRTY] && !resp[CR_ERROR];
endfunction

function automatic void queue_master_beats(input int idx);
    for (int b = 0; b < wr_len[idx]; b++) begin
        exp_w_q.push_back({wr_data[idx][b], b == wr_len[idx] - 1});
    end
endfunction

`endif

// File: bench/tb_ccu_wr.sv
module tb_ccu_wr import ccu_pkg::*; ();

    `include "ccu_wr_model.svh"

    localparam int TIMEOUT   = 400;
    localparam int RUN_LIMIT = 40000;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   aw_valid_i;
    logic                   aw_ready_o;
    logic [ADDR_W-1:0]      aw_addr_i;
    wr_op_e                 aw_op_i;
    domain_e                aw_domain_i;
    logic                   w_valid_i;
    logic                   w_ready_o;
    logic [DATA_W-1:0]      w_data_i;
    logic                   w_last_i;
    logic                   b_valid_o;
    logic                   b_ready_i;
    logic [RESP_W-1:0]      b_resp_o;
    logic [NUM_MASTERS-1:0] dom_inner_i;
    logic [NUM_MASTERS-1:0] dom_outer_i;
    logic [NUM_MASTERS-1:0] dom_initiator_i;
    logic                   ac_valid_o;
    logic                   ac_ready_i;
    logic [ADDR_W-1:0]      ac_addr_o;
    snoop_op_e              ac_op_o;
    logic [NUM_MASTERS-1:0] ac_mask_o;
    logic                   cr_valid_i;
    logic                   cr_ready_o;
    logic [CR_RESP_W-1:0]   cr_resp_i;
    logic                   cd_valid_i;
    logic                   cd_ready_o;
    logic [DATA_W-1:0]      cd_data_i;
    logic                   cd_last_i;
    logic                   mem_aw_valid_o;
    logic                   mem_aw_ready_i;
    logic [ADDR_W-1:0]      mem_aw_addr_o;
    logic                   mem_aw_wrap_o;
    logic                   mem_w_valid_o;
    logic                   mem_w_ready_i;
    logic [DATA_W-1:0]      mem_w_data_o;
    logic                   mem_w_last_o;
    logic                   mem_b_valid_i;
    logic                   mem_b_ready_o;
    logic [RESP_W-1:0]      mem_b_resp_i;

    int      errors;
    int      checks;
    bit      aborted;
    // Transfers seen at the last rising edge
    bit      aw_fire;
    bit      w_fire;
    bit      cr_fire;
    bit      cd_fire;
    bit      mem_b_fire;
    // Progress counters kept by the monitor
    int      aw_cnt;
    int      ac_cnt;
    int      cr_cnt;
    int      cur_idx;
    int      cd_beat;
    bit      wb_pending;
    int      mem_aw_cnt;
    int      mem_wlast_cnt;
    int      b_count;
    int      mem_b_done;
    int      mem_b_wait;
    int      cache_wait;
    int      cd_left;
    mem_aw_t exp_aw;
    beat_t   exp_beat;
    bit      b_kind;

    ccu_wr_top u_ccu_wr_top (.*);

    always #5 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timeout at %0t: no progress while waiting for %s", $time, what);
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h561f_2f13));
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        aw_valid_i      = 1'b0;
        aw_addr_i       = '0;
        aw_op_i         = WRITE_UNIQUE;
        aw_domain_i     = NON_SHAREABLE;
        w_valid_i       = 1'b0;
        w_data_i        = '0;
        w_last_i        = 1'b0;
        b_ready_i       = 1'b0;
        dom_inner_i     = '0;
        dom_outer_i     = '0;
        dom_initiator_i = '0;
        ac_ready_i      = 1'b0;
        cr_valid_i      = 1'b0;
        cr_resp_i       = '0;
        cd_valid_i      = 1'b0;
        cd_data_i       = '0;
        cd_last_i       = 1'b0;
        mem_aw_ready_i  = 1'b0;
        mem_w_ready_i   = 1'b0;
        mem_b_valid_i   = 1'b0;
        mem_b_resp_i    = '0;
        for (int i = 0; i < NUM_WRITES; i++) begin
            wr_addr[i]  = $urandom;
            wr_op[i]    = wr_op_e'($urandom_range(0, 1));
            wr_dom[i]   = domain_e'($urandom_range(0, 3));
            wr_inner[i] = $urandom;
            wr_outer[i] = $urandom;
            wr_init[i]  = $urandom;
            wr_len[i]   = $urandom_range(1, MAX_BEATS);
            for (int b = 0; b < MAX_BEATS; b++) begin
                wr_data[i][b] = $urandom;
            end
        end

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check_value("aw_ready_o", aw_ready_o, 1'b0);
        check_value("ac_valid_o", ac_valid_o, 1'b0);
        check_value("cr_ready_o", cr_ready_o, 1'b0);
        check_value("cd_ready_o", cd_ready_o, 1'b0);
        check_value("mem_aw_valid_o", mem_aw_valid_o, 1'b0);
        check_value("mem_w_valid_o", mem_w_valid_o, 1'b0);
        check_value("w_ready_o", w_ready_o, 1'b0);
        check_value("b_valid_o", b_valid_o, 1'b0);
        $display("reset test done, %0d errors", errors);
        rst_ni = 1'b1;

        cycles = 0;
        while (b_count < NUM_WRITES && !aborted) begin
            cycles++;
            if (cycles > RUN_LIMIT) note_timeout("all master responses");
            @(negedge clk_i);
        end
        // A few idle cycles so that stray traffic still shows up
        repeat (4) @(negedge clk_i);
        check_true(exp_aw_q.size() == 0, "Memory write addresses still expected at the end");
        check_true(exp_w_q.size() == 0, "Memory write beats still expected at the end");
        check_true(b_count == NUM_WRITES, "Not every write received its response");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Master write addresses with masks that change again once the write is taken
    initial begin
        int cnt;
        // First falling edge after reset release
        repeat (4) @(negedge clk_i);
        for (int i = 0; i < NUM_WRITES; i++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk_i);
            aw_valid_i      = 1'b1;
            aw_addr_i       = wr_addr[i];
            aw_op_i         = wr_op[i];
            aw_domain_i     = wr_dom[i];
            dom_inner_i     = wr_inner[i];
            dom_outer_i     = wr_outer[i];
            dom_initiator_i = wr_init[i];
            cnt = 0;
            @(negedge clk_i);
            while (!aw_fire && !aborted) begin
                cnt++;
                if (cnt > TIMEOUT) note_timeout("aw_ready_o");
                @(negedge clk_i);
            end
            aw_valid_i      = 1'b0;
            dom_inner_i     = $urandom;
            dom_outer_i     = $urandom;
            dom_initiator_i = $urandom;
        end
    end

    // Master write data in write order
    initial begin
        int cnt;
        repeat (4) @(negedge clk_i);
        for (int i = 0; i < NUM_WRITES; i++) begin
            for (int b = 0; b < wr_len[i]; b++) begin
                repeat ($urandom_range(0, 1)) @(negedge clk_i);
                w_valid_i = 1'b1;
                w_data_i  = wr_data[i][b];
                w_last_i  = (b == wr_len[i] - 1);
                cnt = 0;
                @(negedge clk_i);
                while (!w_fire && !aborted) begin
                    cnt++;
                    if (cnt > TIMEOUT) note_timeout("w_ready_o");
                    @(negedge clk_i);
                end
                w_valid_i = 1'b0;
            end
        end
    end

    // Ready signals of all agents move at random
    always @(negedge clk_i) begin
        if (rst_ni) begin
            ac_ready_i     = ($urandom_range(0, 3) != 0);
            mem_aw_ready_i = ($urandom_range(0, 3) != 0);
            mem_w_ready_i  = ($urandom_range(0, 3) != 0);
            b_ready_i      = ($urandom_range(0, 1) != 0);
        end
    end

    // Cache agent answers each snoop and sends a full line when data moves
    always @(negedge clk_i) begin
        if (rst_ni && !aborted) begin
            if (cr_fire) begin
                cr_valid_i = 1'b0;
                cache_wait = 0;
                if (cr_resp_i[CR_DATA_XFER]) cd_left = LINE_BEATS;
            end
            if (cd_fire) begin
                cd_valid_i = 1'b0;
                cd_left--;
                cache_wait = 0;
            end
            if (cr_valid_i || cd_valid_i) begin
                cache_wait++;
                if (cache_wait > TIMEOUT) note_timeout("cr_ready_o or cd_ready_o");
            end
            if (!cr_valid_i && cd_left == 0 && ac_cnt > cr_cnt && $urandom_range(0, 1)) begin
                cr_valid_i = 1'b1;
                cr_resp_i  = $urandom_range(0, 7);
            end
            if (!cd_valid_i && cd_left > 0 && $urandom_range(0, 1)) begin
                cd_valid_i = 1'b1;
                cd_data_i  = $urandom;
                cd_last_i  = (cd_left == 1);
            end
        end
    end

    // Memory answers once both address and last beat of a write are in
    always @(negedge clk_i) begin
        if (rst_ni && !aborted) begin
            if (mem_b_fire) begin
                mem_b_valid_i = 1'b0;
                mem_b_done++;
                mem_b_wait = 0;
            end
            if (mem_b_valid_i) begin
                mem_b_wait++;
                if (mem_b_wait > TIMEOUT) note_timeout("mem_b_ready_o");
            end else if (mem_aw_cnt > mem_b_done && mem_wlast_cnt > mem_b_done &&
                         $urandom_range(0, 1)) begin
                mem_b_valid_i = 1'b1;
                mem_b_resp_i  = $urandom_range(0, 3);
            end
        end
    end

    // Monitor and scoreboard
    always @(posedge clk_i) begin
        aw_fire    = aw_valid_i && aw_ready_o;
        w_fire     = w_valid_i && w_ready_o;
        cr_fire    = cr_valid_i && cr_ready_o;
        cd_fire    = cd_valid_i && cd_ready_o;
        mem_b_fire = mem_b_valid_i && mem_b_ready_o;
        if (rst_ni) begin
            if (ac_valid_o && ac_ready_i) begin
                check_true(ac_cnt < aw_cnt, "Snoop issued with no accepted write waiting");
                if (ac_cnt < aw_cnt) begin
                    check_value("ac_addr_o", ac_addr_o, wr_addr[ac_cnt]);
                    check_value("ac_op_o", ac_op_o, expected_snoop_op(wr_op[ac_cnt]));
                    check_value("ac_mask_o", ac_mask_o, domain_targets(wr_dom[ac_cnt],
                                wr_inner[ac_cnt], wr_outer[ac_cnt], wr_init[ac_cnt]));
                end
                cur_idx = ac_cnt;
                ac_cnt++;
            end
            if (aw_fire) aw_cnt++;
            // The snoop response fixes the order of memory writes
            if (cr_fire) begin
                cr_cnt++;
                if (needs_writeback(cr_resp_i)) begin
                    exp_aw_q.push_back({wr_addr[cur_idx], 1'b1});
                    b_kind_q.push_back(1'b1);
                    wb_pending = 1'b1;
                    cd_beat    = 0;
                end else begin
                    queue_master_beats(cur_idx);
                end
                exp_aw_q.push_back({wr_addr[cur_idx], 1'b0});
                b_kind_q.push_back(1'b0);
            end
            if (cd_fire && wb_pending) begin
                exp_w_q.push_back({cd_data_i, cd_beat == LINE_BEATS - 1});
                cd_beat++;
                if (cd_beat == LINE_BEATS) begin
                    queue_master_beats(cur_idx);
                    wb_pending = 1'b0;
                end
            end
            if (mem_aw_valid_o && mem_aw_ready_i) begin
                mem_aw_cnt++;
                check_true(exp_aw_q.size() > 0, "Memory write address with no write expected");
                if (exp_aw_q.size() > 0) begin
                    exp_aw = exp_aw_q.pop_front();
                    check_value("mem_aw_addr_o", mem_aw_addr_o, exp_aw.addr);
                    check_value("mem_aw_wrap_o", mem_aw_wrap_o, exp_aw.wrap);
                end
            end
            if (mem_w_valid_o && mem_w_ready_i) begin
                if (mem_w_last_o) mem_wlast_cnt++;
                check_true(exp_w_q.size() > 0, "Memory write beat with no beat expected");
                if (exp_w_q.size() > 0) begin
                    exp_beat = exp_w_q.pop_front();
                    check_value("mem_w_data_o", mem_w_data_o, exp_beat.data);
                    check_value("mem_w_last_o", mem_w_last_o, exp_beat.last);
                end
            end
            // Write-back responses stay inside the unit
            if (mem_b_fire) begin
                check_true(b_kind_q.size() > 0, "Memory response with no write outstanding");
                if (b_kind_q.size() > 0) begin
                    b_kind = b_kind_q.pop_front();
                    if (!b_kind) exp_b_q.push_back(mem_b_resp_i);
                end
            end
            if (b_valid_o && b_ready_i) begin
                check_true(exp_b_q.size() > 0, "Master response with no data write finished");
                if (exp_b_q.size() > 0) begin
                    check_value("b_resp_o", b_resp_o, exp_b_q.pop_front());
                end
                if (b_count < NUM_WRITES) begin
                    $display("write %0d done: addr %h, %0d beats, resp %0d, %0d errors so far",
                             b_count, wr_addr[b_count], wr_len[b_count], b_resp_o, errors);
                end
                b_count++;
            end
        end
    end

endmodule

// File: compile.f
+incdir+bench
rtl/ccu_pkg.sv
rtl/snoop_req_if.sv
rtl/wr_snoop_decode.sv
rtl/wr_snoop_ctrl.sv
rtl/ccu_wr_top.sv
bench/tb_ccu_wr.sv

// File: rtl/ccu_pkg.sv
package ccu_pkg;

    // Bus and line sizes
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int NUM_MASTERS = 4;
    localparam int LINE_BEATS  = 4;

    // Response word widths
    localparam int RESP_W    = 2;
    localparam int CR_RESP_W = 3;

    // Bit positions inside the snoop response word
    localparam int CR_DATA_XFER  = 0;
    localparam int CR_ERROR      = 1;
    localparam int CR_PASS_DIRTY = 2;

    // Write kinds a cached master can issue
    typedef enum logic {
        WRITE_UNIQUE,
        WRITE_LINE_UNIQUE
    } wr_op_e;

    // Snoop opcodes sent to the other caches
    typedef enum logic {
        CLEAN_INVALID,
        MAKE_INVALID
    } snoop_op_e;

    // Shareability domain of a write
    typedef enum logic [1:0] {
        NON_SHAREABLE,
        INNER_SHAREABLE,
        OUTER_SHAREABLE,
        SYSTEM
    } domain_e;

    // Write snoop controller states
    typedef enum logic [1:0] {
        SNOOP_REQ,
        SNOOP_RESP,
        WRITE_CD,
        WRITE_W
    } wr_fsm_e;

endpackage

// File: rtl/ccu_wr_top.sv
module ccu_wr_top import ccu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Master write address
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  logic [ADDR_W-1:0]      aw_addr_i,
    input  wr_op_e                 aw_op_i,
    input  domain_e                aw_domain_i,
    // Master write data
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    input  logic [DATA_W-1:0]      w_data_i,
    input  logic                   w_last_i,
    // Master write response
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output logic [RESP_W-1:0]      b_resp_o,
    // Domain masks of the initiator
    input  logic [NUM_MASTERS-1:0] dom_inner_i,
    input  logic [NUM_MASTERS-1:0] dom_outer_i,
    input  logic [NUM_MASTERS-1:0] dom_initiator_i,
    // Snoop channels
    output logic                   ac_valid_o,
    input  logic                   ac_ready_i,
    output logic [ADDR_W-1:0]      ac_addr_o,
    output snoop_op_e              ac_op_o,
    output logic [NUM_MASTERS-1:0] ac_mask_o,
    input  logic                   cr_valid_i,
    output logic                   cr_ready_o,
    input  logic [CR_RESP_W-1:0]   cr_resp_i,
    input  logic                   cd_valid_i,
    output logic                   cd_ready_o,
    input  logic [DATA_W-1:0]      cd_data_i,
    input  logic                   cd_last_i,
    // Memory write channels
    output logic                   mem_aw_valid_o,
    input  logic                   mem_aw_ready_i,
    output logic [ADDR_W-1:0]      mem_aw_addr_o,
    output logic                   mem_aw_wrap_o,
    output logic                   mem_w_valid_o,
    input  logic                   mem_w_ready_i,
    output logic [DATA_W-1:0]      mem_w_data_o,
    output logic                   mem_w_last_o,
    input  logic                   mem_b_valid_i,
    output logic                   mem_b_ready_o,
    input  logic [RESP_W-1:0]      mem_b_resp_i
);

    snoop_req_if snoop_req ();

    wr_snoop_decode u_wr_snoop_decode (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .aw_valid_i      (aw_valid_i),
        .aw_ready_o      (aw_ready_o),
        .aw_addr_i       (aw_addr_i),
        .aw_op_i         (aw_op_i),
        .aw_domain_i     (aw_domain_i),
        .dom_inner_i     (dom_inner_i),
        .dom_outer_i     (dom_outer_i),
        .dom_initiator_i (dom_initiator_i),
        .req             (snoop_req.src)
    );

    wr_snoop_ctrl u_wr_snoop_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req            (snoop_req.dst),
        .ac_valid_o     (ac_valid_o),
        .ac_ready_i     (ac_ready_i),
        .ac_addr_o      (ac_addr_o),
        .ac_op_o        (ac_op_o),
        .ac_mask_o      (ac_mask_o),
        .cr_valid_i     (cr_valid_i),
        .cr_ready_o     (cr_ready_o),
        .cr_resp_i      (cr_resp_i),
        .cd_valid_i     (cd_valid_i),
        .cd_ready_o     (cd_ready_o),
        .cd_data_i      (cd_data_i),
        .cd_last_i      (cd_last_i),
        .w_valid_i      (w_valid_i),
        .w_ready_o      (w_ready_o),
        .w_data_i       (w_data_i),
        .w_last_i       (w_last_i),
        .b_valid_o      (b_valid_o),
        .b_ready_i      (b_ready_i),
        .b_resp_o       (b_resp_o),
        .mem_aw_valid_o (mem_aw_valid_o),
        .mem_aw_ready_i (mem_aw_ready_i),
        .mem_aw_addr_o  (mem_aw_addr_o),
        .mem_aw_wrap_o  (mem_aw_wrap_o),
        .mem_w_valid_o  (mem_w_valid_o),
        .mem_w_ready_i  (mem_w_ready_i),
        .mem_w_data_o   (mem_w_data_o),
        .mem_w_last_o   (mem_w_last_o),
        .mem_b_valid_i  (mem_b_valid_i),
        .mem_b_ready_o  (mem_b_ready_o),
        .mem_b_resp_i   (mem_b_resp_i)
    );

endmodule

// File: rtl/snoop_req_if.sv
interface snoop_req_if import ccu_pkg::*; ();

    // Decoded snoop request, one per master write
    logic                   valid;
    logic                   ready;
    logic [ADDR_W-1:0]      addr;
    snoop_op_e              op;
    logic [NUM_MASTERS-1:0] mask;

    // Decode stage side
    modport src (
        output valid,
        output addr,
        output op,
        output mask,
        input  ready
    );

    // Controller side
    modport dst (
        input  valid,
        input  addr,
        input  op,
        input  mask,
        output ready
    );

endinterface

// File: rtl/wr_snoop_ctrl.sv
module wr_snoop_ctrl import ccu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    snoop_req_if.dst               req,
    // Snoop address
    output logic                   ac_valid_o,
    input  logic                   ac_ready_i,
    output logic [ADDR_W-1:0]      ac_addr_o,
    output snoop_op_e              ac_op_o,
    output logic [NUM_MASTERS-1:0] ac_mask_o,
    // Snoop response and data
    input  logic                   cr_valid_i,
    output logic                   cr_ready_o,
    input  logic [CR_RESP_W-1:0]   cr_resp_i,
    input  logic                   cd_valid_i,
    output logic                   cd_ready_o,
    input  logic [DATA_W-1:0]      cd_data_i,
    input  logic                   cd_last_i,
    // Master write data and response
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    input  logic [DATA_W-1:0]      w_data_i,
    input  logic                   w_last_i,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output logic [RESP_W-1:0]      b_resp_o,
    // Memory write channels
    output logic                   mem_aw_valid_o,
    input  logic                   mem_aw_ready_i,
    output logic [ADDR_W-1:0]      mem_aw_addr_o,
    output logic                   mem_aw_wrap_o,
    output logic                   mem_w_valid_o,
    input  logic                   mem_w_ready_i,
    output logic [DATA_W-1:0]      mem_w_data_o,
    output logic                   mem_w_last_o,
    input  logic                   mem_b_valid_i,
    output logic                   mem_b_ready_o,
    input  logic [RESP_W-1:0]      mem_b_resp_i
);

    wr_fsm_e           state_d;
    wr_fsm_e           state_q;
    logic [ADDR_W-1:0] addr_q;
    logic              aw_valid_d;
    logic              aw_valid_q;
    logic              ignore_cd_d;
    logic              ignore_cd_q;
    logic              cd_last_d;
    logic              cd_last_q;
    logic              w_last_d;
    logic              w_last_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= SNOOP_REQ;
            aw_valid_q  <= 1'b0;
            ignore_cd_q <= 1'b0;
            cd_last_q   <= 1'b0;
            w_last_q    <= 1'b0;
        end else begin
            state_q     <= state_d;
            aw_valid_q  <= aw_valid_d;
            ignore_cd_q <= ignore_cd_d;
            cd_last_q   <= cd_last_d;
            w_last_q    <= w_last_d;
        end
    end

    // Address kept for both memory writes
    always_ff @(posedge clk_i) begin
        if (ac_valid_o && ac_ready_i) begin
            addr_q <= req.addr;
        end
    end

    assign ac_addr_o = req.addr;
    assign ac_op_o   = req.op;
    assign ac_mask_o = req.mask;

    assign mem_aw_valid_o = aw_valid_q;
    assign mem_aw_addr_o  = addr_q;
    // Snooped line comes back as a wrapping burst
    assign mem_aw_wrap_o  = (state_q == WRITE_CD);
    assign b_resp_o       = mem_b_resp_i;

    always_comb begin
        state_d       = state_q;
        aw_valid_d    = aw_valid_q;
        ignore_cd_d   = ignore_cd_q;
        cd_last_d     = cd_last_q;
        w_last_d      = w_last_q;
        req.ready     = 1'b0;
        ac_valid_o    = 1'b0;
        cr_ready_o    = 1'b0;
        cd_ready_o    = 1'b0;
        w_ready_o     = 1'b0;
        b_valid_o     = 1'b0;
        mem_w_valid_o = 1'b0;
        mem_w_data_o  = w_data_i;
        mem_w_last_o  = w_last_i;
        mem_b_ready_o = 1'b0;

        if (aw_valid_q && mem_aw_ready_i) begin
            aw_valid_d = 1'b0;
        end

        case (state_q)
            SNOOP_REQ: begin
                ignore_cd_d = 1'b0;
                cd_last_d   = 1'b0;
                w_last_d    = 1'b0;
                ac_valid_o  = req.valid;
                req.ready   = ac_ready_i;
                if (ac_valid_o && ac_ready_i) begin
                    state_d = SNOOP_RESP;
                end
            end
            SNOOP_RESP: begin
                cr_ready_o = 1'b1;
                if (cr_valid_i) begin
                    if (cr_resp_i[CR_DATA_XFER]) begin
                        // Clean or faulty data is taken but not written back
                        if (cr_resp_i[CR_ERROR] || !cr_resp_i[CR_PASS_DIRTY]) begin
                            ignore_cd_d = 1'b1;
                        end else begin
                            aw_valid_d = 1'b1;
                        end
                        state_d = WRITE_CD;
                    end else begin
                        aw_valid_d = 1'b1;
                        state_d    = WRITE_W;
                    end
                end
            end
            WRITE_CD: begin
                mem_w_data_o  = cd_data_i;
                mem_w_last_o  = cd_last_i;
                mem_w_valid_o = cd_valid_i && !cd_last_q && !ignore_cd_q;
                cd_ready_o    = !cd_last_q && (ignore_cd_q || mem_w_ready_i);
                // Write-back response stays inside the unit
                mem_b_ready_o = 1'b1;
                if (cd_valid_i && cd_ready_o && cd_last_i) begin
                    cd_last_d = 1'b1;
                end
                if ((mem_b_valid_i && mem_b_ready_o) || (cd_last_q && ignore_cd_q)) begin
                    aw_valid_d = 1'b1;
                    state_d    = WRITE_W;
                end
            end
            WRITE_W: begin
                if (!w_last_q) begin
                    mem_w_valid_o = w_valid_i;
                    w_ready_o     = mem_w_ready_i;
                end
                if (w_valid_i && w_ready_o && w_last_i) begin
                    w_last_d = 1'b1;
                end
                // Memory response goes straight back to the master
                mem_b_ready_o = b_ready_i;
                b_valid_o     = mem_b_valid_i;
                if (mem_b_valid_i && b_ready_i) begin
                    state_d = SNOOP_REQ;
                end
            end
            default: begin
                state_d = SNOOP_REQ;
            end
        endcase
    end

endmodule

// File: rtl/wr_snoop_decode.sv
module wr_snoop_decode import ccu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  logic [ADDR_W-1:0]      aw_addr_i,
    input  wr_op_e                 aw_op_i,
    input  domain_e                aw_domain_i,
    input  logic [NUM_MASTERS-1:0] dom_inner_i,
    input  logic [NUM_MASTERS-1:0] dom_outer_i,
    input  logic [NUM_MASTERS-1:0] dom_initiator_i,
    snoop_req_if.src               req
);

    logic                   active_q;
    logic                   valid_q;
    logic                   aw_hs;
    logic                   take;
    logic [ADDR_W-1:0]      addr_q;
    snoop_op_e              op_d;
    snoop_op_e              op_q;
    logic [NUM_MASTERS-1:0] mask_d;
    logic [NUM_MASTERS-1:0] mask_q;

    // Entry leaves when the controller accepts it
    assign take = valid_q && req.ready;

    // Master held off for the first cycle out of reset
    assign aw_ready_o = active_q && (!valid_q || req.ready);
    assign aw_hs      = aw_valid_i && aw_ready_o;

    // Write kind to snoop opcode
    always_comb begin
        case (aw_op_i)
            WRITE_LINE_UNIQUE: op_d = MAKE_INVALID;
            default:           op_d = CLEAN_INVALID;
        endcase
    end

    // Snoop targets from the shareability domain
    always_comb begin
        case (aw_domain_i)
            INNER_SHAREABLE: mask_d = dom_inner_i;
            OUTER_SHAREABLE: mask_d = dom_outer_i;
            SYSTEM:          mask_d = ~dom_initiator_i;
            default:         mask_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            active_q <= 1'b1;
            if (aw_hs) begin
                valid_q <= 1'b1;
            end else if (take) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Payload of the single entry with masks sampled at the AW transfer
    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            addr_q <= aw_addr_i;
            op_q   <= op_d;
            mask_q <= mask_d;
        end
    end

    assign req.valid = valid_q;
    assign req.addr  = addr_q;
    assign req.op    = op_q;
    assign req.mask  = mask_q;

endmodule
